/* design/x86_decode_pkg.sv */
`default_nettype none

package x86_decode_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes and widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int packet_bytes      = 16;  // one fetch packet
    localparam int max_prefixes      = 3;   // scan limit for leading prefixes
    localparam int window_bytes      = 13;  // opcode onward, after worst-case shift
    localparam int eip_width         = 32;
    localparam int len_width         = 4;   // 14 byte max instr fits
    localparam int full_imm_bytes    = 4;
    localparam int full_imm_bytes_16 = 2;   // full imm under 66

    typedef logic [7:0] byte_t;
    typedef logic [2:0] reg_idx_t;          // eax..edi numbering

    ////////////////////////////////////////////////////////////////////////////
    // prefix bytes
    ////////////////////////////////////////////////////////////////////////////
    localparam byte_t pfx_rep    = 8'hF3;
    localparam byte_t pfx_opsize = 8'h66;
    localparam byte_t pfx_es     = 8'h26;
    localparam byte_t pfx_cs     = 8'h2E;
    localparam byte_t pfx_ss     = 8'h36;
    localparam byte_t pfx_ds     = 8'h3E;
    localparam byte_t pfx_fs     = 8'h64;
    localparam byte_t pfx_gs     = 8'h65;

    // segment register numbering, es first
    typedef enum logic [2:0] {es, cs, ss, ds, fs, gs} seg_t;

    typedef enum logic [3:0] {
        add_rm_r,     // 01
        add_r_rm,     // 03
        add_acc_imm,  // 05, eax implied
        add_rm_imm8,  // 83 /0
        mov_rm_r,     // 89
        mov_r_rm,     // 8B
        nop,          // 90
        mov_r_imm,    // B8+r
        mov_rm_imm,   // C7
        jmp_rel8,     // EB
        jmp_rel32,    // E9
        illegal       // anything else
    } op_kind_t;

endpackage

`default_nettype wire

/* design/prefix_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module prefix_decode
    import x86_decode_pkg::*;
(
    input  byte_t [0:packet_bytes-1] packet,  // byte 0 first in memory
    output logic                     rep,
    output logic                     opsize16,
    output logic                     seg_override,
    output seg_t                     seg_sel,
    output logic [1:0]               num_prefixes,
    output byte_t [0:window_bytes-1] window   // window[0] is the opcode
);

    function automatic logic is_prefix(input byte_t b);
        case (b)
            pfx_rep, pfx_opsize, pfx_es, pfx_cs,
            pfx_ss, pfx_fs, pfx_gs, pfx_ds: return 1'b1;
            default:                        return 1'b0;
        endcase
    endfunction

    function automatic seg_t seg_of(input byte_t b);
        case (b)
            pfx_es:  return es;
            pfx_cs:  return cs;
            pfx_ss:  return ss;
            pfx_fs:  return fs;
            pfx_gs:  return gs;
            default: return ds;  // 3E and no override
        endcase
    endfunction

    // scan stops at the first non-prefix byte
    always_comb begin
        logic       scanning;
        logic [1:0] cnt;
        scanning     = 1'b1;
        cnt          = 2'd0;
        rep          = 1'b0;
        opsize16     = 1'b0;
        seg_override = 1'b0;
        seg_sel      = ds;  // default data segment
        for (int i = 0; i < max_prefixes; i++) begin
            if (scanning && is_prefix(packet[i])) begin
                cnt = cnt + 2'd1;
                case (packet[i])
                    pfx_rep:    rep = 1'b1;
                    pfx_opsize: opsize16 = 1'b1;
                    default: begin
                        seg_override = 1'b1;
                        seg_sel      = seg_of(packet[i]);  // later one overwrites
                    end
                endcase
            end else begin
                scanning = 1'b0;
            end
        end
        num_prefixes = cnt;
    end

    // shift left by prefix count so opcode lands at byte 0
    always_comb begin
        for (int i = 0; i < window_bytes; i++) begin
            window[i] = packet[i + int'(num_prefixes)];  // max index 15
        end
    end

endmodule

`default_nettype wire

/* design/opcode_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module opcode_decode
    import x86_decode_pkg::*;
(
    input  byte_t                opcode,
    input  logic                 opsize16,
    output op_kind_t             kind,
    output logic                 has_modrm,
    output logic [len_width-1:0] imm_bytes,
    output logic                 is_br,
    output reg_idx_t             reg1       // register named by the opcode itself
);

    logic [len_width-1:0] full_imm;  // imm32, or imm16 under 66

    assign full_imm = opsize16 ? len_width'(full_imm_bytes_16) : len_width'(full_imm_bytes);

    ////////////////////////////////////////////////////////////////////////////
    // opcode table
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        kind      = illegal;   // unlisted opcodes fall through as 1 byte
        has_modrm = 1'b0;
        imm_bytes = '0;
        is_br     = 1'b0;
        reg1      = '0;
        casez (opcode)
            8'h01: begin
                kind      = add_rm_r;
                has_modrm = 1'b1;
            end
            8'h03: begin
                kind      = add_r_rm;
                has_modrm = 1'b1;
            end
            8'h05: begin
                kind      = add_acc_imm;
                imm_bytes = full_imm;
                reg1      = 3'd0;  // eax
            end
            8'h83: begin
                kind      = add_rm_imm8;  // /0 group member
                has_modrm = 1'b1;
                imm_bytes = len_width'(1);
            end
            8'h89: begin
                kind      = mov_rm_r;
                has_modrm = 1'b1;
            end
            8'h8B: begin
                kind      = mov_r_rm;
                has_modrm = 1'b1;
            end
            8'h90: kind = nop;
            8'b1011_1???: begin
                kind      = mov_r_imm;
                imm_bytes = full_imm;
                reg1      = opcode[2:0];  // register in low opcode bits
            end
            8'hC7: begin
                kind      = mov_rm_imm;
                has_modrm = 1'b1;
                imm_bytes = full_imm;
            end
            8'hEB: begin
                kind      = jmp_rel8;
                imm_bytes = len_width'(1);
                is_br     = 1'b1;
            end
            8'hE9: begin
                kind      = jmp_rel32;
                imm_bytes = full_imm;  // rel16 under 66
                is_br     = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/modrm_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module modrm_decode
    import x86_decode_pkg::*;
(
    input  byte_t                modrm,
    input  byte_t                sib,          // only meaningful when rm is 4
    input  logic                 has_modrm,
    output reg_idx_t             reg2,
    output reg_idx_t             base_reg,
    output logic                 use_base,
    output reg_idx_t             index_reg,
    output logic                 use_index,
    output logic [1:0]           scale,
    output logic                 is_mem,
    output logic [len_width-1:0] modrm_bytes,  // modrm + sib + disp
    output logic [len_width-1:0] disp_bytes
);

    logic [1:0] mod_f;
    reg_idx_t   reg_f;
    reg_idx_t   rm_f;
    logic       has_sib;
    logic       no_base;  // disp32-only address

    assign mod_f = modrm[7:6];
    assign reg_f = modrm[5:3];
    assign rm_f  = modrm[2:0];

    assign has_sib = (mod_f != 2'b11) && (rm_f == 3'd4);
    assign no_base = (mod_f == 2'b00) && (has_sib ? (sib[2:0] == 3'd5) : (rm_f == 3'd5));

    always_comb begin
        reg2        = '0;
        base_reg    = '0;
        use_base    = 1'b0;
        index_reg   = '0;
        use_index   = 1'b0;
        scale       = '0;
        is_mem      = 1'b0;
        disp_bytes  = '0;
        modrm_bytes = '0;
        if (has_modrm) begin
            reg2 = reg_f;
            if (mod_f == 2'b11) begin
                base_reg    = rm_f;  // register operand
                use_base    = 1'b1;
                modrm_bytes = len_width'(1);
            end else begin
                is_mem   = 1'b1;
                base_reg = has_sib ? sib[2:0] : rm_f;
                use_base = !no_base;
                if (has_sib) begin
                    scale     = sib[7:6];
                    index_reg = sib[5:3];
                    use_index = (sib[5:3] != 3'd4);  // index 4 means none
                end
                if (no_base || mod_f == 2'b10) begin
                    disp_bytes = len_width'(4);
                end else if (mod_f == 2'b01) begin
                    disp_bytes = len_width'(1);
                end
                modrm_bytes = len_width'(1) + len_width'(has_sib) + disp_bytes;
            end
        end
    end

endmodule

`default_nettype wire

/* design/disp_imm_length.sv */
`timescale 1ns/1ps
`default_nettype none

module disp_imm_length
    import x86_decode_pkg::*;
(
    input  byte_t [0:window_bytes-1] window,
    input  logic [1:0]               num_prefixes,
    input  logic [len_width-1:0]     modrm_bytes,
    input  logic [len_width-1:0]     disp_bytes,
    input  logic [len_width-1:0]     imm_bytes,
    output logic [31:0]              disp,
    output logic [31:0]              imm,
    output logic [len_width-1:0]     length
);

    logic [len_width-1:0] disp_pos;  // first disp byte in window
    logic [len_width-1:0] imm_pos;   // first imm byte, right after disp
    logic [31:0]          disp_raw;
    logic [31:0]          imm_raw;

    // out of window reads give zero
    function automatic byte_t pick(input byte_t [0:window_bytes-1] w, input int pos);
        if (pos < window_bytes) begin
            return w[pos];
        end
        return '0;
    endfunction

    assign disp_pos = len_width'(1) + modrm_bytes - disp_bytes;
    assign imm_pos  = len_width'(1) + modrm_bytes;

    // little endian gather, lowest address into bits 7:0
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            disp_raw[8*i +: 8] = pick(window, int'(disp_pos) + i);
            imm_raw[8*i +: 8]  = pick(window, int'(imm_pos) + i);
        end
    end

    always_comb begin
        case (disp_bytes)
            len_width'(1): disp = {{24{disp_raw[7]}}, disp_raw[7:0]};  // disp8 sign ext
            len_width'(4): disp = disp_raw;
            default:       disp = '0;
        endcase
        case (imm_bytes)
            len_width'(1): imm = {{24{imm_raw[7]}}, imm_raw[7:0]};  // imm8 sign ext
            len_width'(2): imm = {16'h0000, imm_raw[15:0]};         // imm16 zero ext
            len_width'(4): imm = imm_raw;
            default:       imm = '0;
        endcase
    end

    // prefixes + opcode + modrm/sib/disp + imm
    assign length = len_width'(num_prefixes) + len_width'(1) + modrm_bytes + imm_bytes;

endmodule

`default_nettype wire

/* design/eip_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module eip_tracker
    import x86_decode_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid,
    input  logic                 stall,       // decode queue full
    input  logic                 is_init,
    input  logic                 is_resteer,  // writeback redirect
    input  logic                 br_taken,    // predictor says taken
    input  logic [eip_width-1:0] init_eip,
    input  logic [eip_width-1:0] wb_eip,
    input  logic [eip_width-1:0] bp_eip,
    input  logic [len_width-1:0] length,
    output logic [eip_width-1:0] eip
);

    logic [eip_width-1:0] seq_eip;  // fall-through address

    assign seq_eip = eip + {{(eip_width-len_width){1'b0}}, length};

    // init beats resteer beats predicted branch beats sequential
    always_ff @(posedge clk) begin
        if (rst) begin
            eip <= '0;
        end else if (is_init) begin
            eip <= init_eip;
        end else if (is_resteer) begin
            eip <= wb_eip;
        end else if (br_taken) begin
            eip <= bp_eip;
        end else if (valid && !stall) begin
            eip <= seq_eip;
        end
    end

endmodule

`default_nettype wire

/* design/decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_top
    import x86_decode_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid_in,
    input  logic                     stall,
    input  byte_t [0:packet_bytes-1] packet_in,  // byte 0 in top bits
    input  logic                     is_init,
    input  logic [eip_width-1:0]     init_eip,
    input  logic                     is_resteer,
    input  logic [eip_width-1:0]     wb_eip,
    input  logic                     br_taken,
    input  logic [eip_width-1:0]     bp_eip,
    output logic                     valid_out,
    output logic                     rep,
    output logic                     opsize16,
    output logic                     seg_override,
    output seg_t                     seg_sel,
    output op_kind_t                 kind,
    output logic                     is_br,
    output reg_idx_t                 reg1,
    output reg_idx_t                 reg2,
    output reg_idx_t                 base_reg,
    output logic                     use_base,
    output reg_idx_t                 index_reg,
    output logic                     use_index,
    output logic [1:0]               scale,
    output logic                     is_mem,
    output logic [31:0]              disp,
    output logic [31:0]              imm,
    output logic [len_width-1:0]     length,
    output logic [eip_width-1:0]     eip
);

    logic [1:0]               num_prefixes;
    byte_t [0:window_bytes-1] window;       // opcode aligned bytes
    logic                     has_modrm;
    logic [len_width-1:0]     imm_bytes;
    logic [len_width-1:0]     modrm_bytes;
    logic [len_width-1:0]     disp_bytes;

    assign valid_out = valid_in;  // decode is single cycle

    ////////////////////////////////////////////////////////////////////////////
    // prefix strip and opcode alignment
    ////////////////////////////////////////////////////////////////////////////
    prefix_decode u_prefix (
        .packet(packet_in), .rep(rep), .opsize16(opsize16),
        .seg_override(seg_override), .seg_sel(seg_sel),
        .num_prefixes(num_prefixes), .window(window)
    );

    ////////////////////////////////////////////////////////////////////////////
    // opcode and addressing
    ////////////////////////////////////////////////////////////////////////////
    opcode_decode u_opcode (
        .opcode(window[0]), .opsize16(opsize16), .kind(kind),
        .has_modrm(has_modrm), .imm_bytes(imm_bytes), .is_br(is_br), .reg1(reg1)
    );

    modrm_decode u_modrm (
        .modrm(window[1]), .sib(window[2]), .has_modrm(has_modrm),
        .reg2(reg2), .base_reg(base_reg), .use_base(use_base),
        .index_reg(index_reg), .use_index(use_index), .scale(scale), .is_mem(is_mem),
        .modrm_bytes(modrm_bytes), .disp_bytes(disp_bytes)
    );

    ////////////////////////////////////////////////////////////////////////////
    // operand bytes, length and eip
    ////////////////////////////////////////////////////////////////////////////
    disp_imm_length u_disp_imm (
        .window(window), .num_prefixes(num_prefixes), .modrm_bytes(modrm_bytes),
        .disp_bytes(disp_bytes), .imm_bytes(imm_bytes),
        .disp(disp), .imm(imm), .length(length)
    );

    eip_tracker u_eip (
        .clk(clk), .rst(rst), .valid(valid_in), .stall(stall),
        .is_init(is_init), .is_resteer(is_resteer), .br_taken(br_taken),
        .init_eip(init_eip), .wb_eip(wb_eip), .bp_eip(bp_eip),
        .length(length), .eip(eip)
    );

endmodule

`default_nettype wire

/* sim/decode_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // reset held over the first 3 rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #10 rst = 1'b0;  // release off the edge
    end

endmodule

`default_nettype wire

/* sim/tb_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top
    import x86_decode_pkg::*;
();

    localparam int    max_vectors   = 64;  // queue cap
    localparam int    reset_cycles  = 3;
    localparam int    timeout_slack = 20;  // spare cycles past the last vector
    localparam int    drive_skew    = 10;  // ns after rising edge
    localparam string vec_path      = "sim/decode_vectors.txt";

    logic                     clk;
    logic                     rst;
    logic                     valid_in;
    logic                     stall;
    byte_t [0:packet_bytes-1] packet_in;  // byte 0 leftmost in the file
    logic                     is_init;
    logic [eip_width-1:0]     init_eip;
    logic                     is_resteer;
    logic [eip_width-1:0]     wb_eip;
    logic                     br_taken;
    logic [eip_width-1:0]     bp_eip;

    logic                     valid_out;
    logic                     rep;
    logic                     opsize16;
    logic                     seg_override;
    seg_t                     seg_sel;
    op_kind_t                 kind;
    logic                     is_br;
    reg_idx_t                 reg1;
    reg_idx_t                 reg2;
    reg_idx_t                 base_reg;
    logic                     use_base;
    reg_idx_t                 index_reg;
    logic                     use_index;
    logic [1:0]               scale;
    logic                     is_mem;
    logic [31:0]              disp;
    logic [31:0]              imm;
    logic [len_width-1:0]     length;
    logic [eip_width-1:0]     eip;

    string vec_lines[$];  // one raw line per cycle
    int    vec_count;     // from the file header
    int    errors;
    int    checks;
    int    cycle_count;
    int    cycle_limit;

    decode_clock u_clock (.clk(clk), .rst(rst));

    decode_top dut (.*);

    ////////////////////////////////////////////////////////////////////////////
    // vector file parsing
    ////////////////////////////////////////////////////////////////////////////
    function automatic bit skip_line(input string line);
        if (line.len() < 2) return 1'b1;  // blank
        return line.substr(0, 1) == "//";
    endfunction

    // column of the | between inputs and expected values
    function automatic int split_at(input string line);
        for (int i = 0; i < line.len(); i++) begin
            if (line.getc(i) == "|") return i;
        end
        return -1;
    endfunction

    task automatic load_vectors();
        int    fd;
        int    got;
        bit    have_count;
        string line;
        have_count = 1'b0;
        fd = $fopen(vec_path, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the vector file %s", vec_path);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            if (got > 0 && !skip_line(line)) begin
                if (!have_count) begin
                    got        = $sscanf(line, "%d", vec_count);
                    have_count = 1'b1;  // first entry is the count
                end else if (vec_lines.size() < max_vectors) begin
                    vec_lines.push_back(line);
                end
            end
        end
        $fclose(fd);
        if (vec_lines.size() != vec_count || vec_count == 0) begin
            errors++;
            $display("vector file header says %0d vectors but %0d lines were read",
                     vec_count, vec_lines.size());
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drive and check
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_field(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s expected %0h got %0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic run_vector(input int idx, input string line);
        int           cut;
        int           n_in;
        int           n_exp;
        string        in_part;
        string        exp_part;
        logic [31:0]  f_valid, f_stall, f_init, f_resteer, f_br;
        logic [31:0]  f_init_eip, f_wb_eip, f_bp_eip;
        logic [127:0] f_packet;
        logic [31:0]  e_rep, e_opsize, e_segov, e_seg, e_kind, e_br;
        logic [31:0]  e_reg1, e_reg2, e_base, e_ubase, e_index, e_uindex;
        logic [31:0]  e_scale, e_mem, e_disp, e_imm, e_len, e_eip;
        cut = split_at(line);
        if (cut < 1) begin
            errors++;
            $display("vector %0d has no separator before its expected values", idx);
            return;
        end
        in_part  = line.substr(0, cut - 1);
        exp_part = line.substr(cut + 1, line.len() - 1);
        n_in  = $sscanf(in_part, "%h %h %h %h %h %h %h %h %h",
                        f_valid, f_stall, f_init, f_resteer, f_br,
                        f_init_eip, f_wb_eip, f_bp_eip, f_packet);
        n_exp = $sscanf(exp_part, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        e_rep, e_opsize, e_segov, e_seg, e_kind, e_br,
                        e_reg1, e_reg2, e_base, e_ubase, e_index, e_uindex,
                        e_scale, e_mem, e_disp, e_imm, e_len, e_eip);
        if (n_in != 9 || n_exp != 18) begin
            errors++;
            $display("vector %0d could not be parsed", idx);
            return;
        end

        @(posedge clk);
        #(drive_skew);
        valid_in   = f_valid[0];
        stall      = f_stall[0];
        is_init    = f_init[0];
        is_resteer = f_resteer[0];
        br_taken   = f_br[0];
        init_eip   = f_init_eip;
        wb_eip     = f_wb_eip;
        bp_eip     = f_bp_eip;
        packet_in  = f_packet;

        @(negedge clk);  // decode settled, eip stable
        check_field("valid_out", 32'(valid_out), f_valid);
        check_field("rep", 32'(rep), e_rep);
        check_field("opsize16", 32'(opsize16), e_opsize);
        check_field("seg_override", 32'(seg_override), e_segov);
        check_field("seg_sel", 32'(seg_sel), e_seg);
        check_field("kind", 32'(kind), e_kind);
        check_field("is_br", 32'(is_br), e_br);
        check_field("reg1", 32'(reg1), e_reg1);
        check_field("reg2", 32'(reg2), e_reg2);
        check_field("base_reg", 32'(base_reg), e_base);
        check_field("use_base", 32'(use_base), e_ubase);
        check_field("index_reg", 32'(index_reg), e_index);
        check_field("use_index", 32'(use_index), e_uindex);
        check_field("scale", 32'(scale), e_scale);
        check_field("is_mem", 32'(is_mem), e_mem);
        check_field("disp", disp, e_disp);
        check_field("imm", imm, e_imm);
        check_field("length", 32'(length), e_len);
        check_field("eip", eip, e_eip);  // value loaded by the previous cycle
    endtask

    // run limit guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, vectors not done after %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        valid_in    = 1'b0;
        stall       = 1'b0;
        is_init     = 1'b0;
        is_resteer  = 1'b0;
        br_taken    = 1'b0;
        init_eip    = '0;
        wb_eip      = '0;
        bp_eip      = '0;
        packet_in   = '0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        vec_count   = 0;
        load_vectors();
        cycle_limit = reset_cycles + vec_lines.size() + timeout_slack;
        @(negedge rst);
        foreach (vec_lines[k]) begin
            run_vector(k, vec_lines[k]);
        end
        $display("%0d vectors, %0d checks, %0d errors", vec_lines.size(), checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* decode_top.f */
design/x86_decode_pkg.sv
design/prefix_decode.sv
design/opcode_decode.sv
design/modrm_decode.sv
design/disp_imm_length.sv
design/eip_tracker.sv
design/decode_top.sv
sim/decode_clock.sv
sim/tb_decode_top.sv

/* Makefile */
# Verilator build and run for the x86 decode stage

TOP       ?= tb_decode_top
LINT_TOP  ?= decode_top
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing
FILELIST  ?= decode_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* sim/decode_vectors.txt */
// inputs: valid stall is_init is_resteer br_taken init_eip wb_eip bp_eip packet (byte 0 first)
// after |: rep opsize16 seg_override seg_sel kind is_br reg1 reg2 base_reg use_base index_reg use_index scale is_mem disp imm length eip
25
0 0 0 0 0 00000000 00000000 00000000 90000000000000000000000000000000 | 0 0 0 3 6 0 0 0 0 0 0 0 0 0 00000000 00000000 1 00000000
0 0 1 0 0 00001000 00000000 00000000 90000000000000000000000000000000 | 0 0 0 3 6 0 0 0 0 0 0 0 0 0 00000000 00000000 1 00000000
1 0 0 0 0 00000000 00000000 00000000 01D80000000000000000000000000000 | 0 0 0 3 0 0 0 3 0 1 0 0 0 0 00000000 00000000 2 00001000
1 1 0 0 0 00000000 00000000 00000000 8B450800000000000000000000000000 | 0 0 0 3 5 0 0 0 5 1 0 0 0 1 00000008 00000000 3 00001002
1 0 0 0 0 00000000 00000000 00000000 8B450800000000000000000000000000 | 0 0 0 3 5 0 0 0 5 1 0 0 0 1 00000008 00000000 3 00001002
1 0 0 0 0 00000000 00000000 00000000 89848B78563412000000000000000000 | 0 0 0 3 4 0 0 0 3 1 1 1 2 1 12345678 00000000 7 00001005
1 0 0 0 0 00000000 00000000 00000000 03042400000000000000000000000000 | 0 0 0 3 1 0 0 0 4 1 4 0 0 1 00000000 00000000 3 0000100C
1 0 0 0 0 00000000 00000000 00000000 8B0D4433221100000000000000000000 | 0 0 0 3 5 0 0 1 5 0 0 0 0 1 11223344 00000000 6 0000100F
1 0 0 0 0 00000000 00000000 00000000 8B148500100000000000000000000000 | 0 0 0 3 5 0 0 2 5 0 0 1 2 1 00001000 00000000 7 00001015
1 0 0 0 0 00000000 00000000 00000000 015EFC00000000000000000000000000 | 0 0 0 3 0 0 0 3 6 1 0 0 0 1 FFFFFFFC 00000000 3 0000101C
1 0 0 0 0 00000000 00000000 00000000 05785634120000000000000000000000 | 0 0 0 3 2 0 0 0 0 0 0 0 0 0 00000000 12345678 5 0000101F
1 0 0 0 0 00000000 00000000 00000000 66053412000000000000000000000000 | 0 1 0 3 2 0 0 0 0 0 0 0 0 0 00000000 00001234 4 00001024
1 0 0 0 0 00000000 00000000 00000000 83C08000000000000000000000000000 | 0 0 0 3 3 0 0 0 0 1 0 0 0 0 00000000 FFFFFF80 3 00001028
1 0 0 0 0 00000000 00000000 00000000 F32E64C7849D78563412EFBEADDE0000 | 1 0 1 4 8 0 0 0 5 1 3 1 2 1 12345678 DEADBEEF E 0000102B
1 0 0 0 0 00000000 00000000 00000000 66B9CDAB999900000000000000000000 | 0 1 0 3 7 0 1 0 0 0 0 0 0 0 00000000 0000ABCD 4 00001039
1 0 0 0 0 00000000 00000000 00000000 2666C700112200000000000000000000 | 0 1 1 0 8 0 0 0 0 1 0 0 0 1 00000000 00002211 6 0000103D
1 0 0 0 0 00000000 00000000 00000000 90F30000000000000000000000000000 | 0 0 0 3 6 0 0 0 0 0 0 0 0 0 00000000 00000000 1 00001043
1 0 0 0 0 00000000 00000000 00000000 3E65BB01000000000000000000000000 | 0 0 1 5 7 0 3 0 0 0 0 0 0 0 00000000 00000001 7 00001044
1 0 0 0 1 00000000 00000000 00002000 EBF00000000000000000000000000000 | 0 0 0 3 9 1 0 0 0 0 0 0 0 0 00000000 FFFFFFF0 2 0000104B
1 0 0 1 1 00000000 00003000 00004000 E9000100000000000000000000000000 | 0 0 0 3 A 1 0 0 0 0 0 0 0 0 00000000 00000100 5 00002000
1 0 1 1 1 00005000 00006000 00007000 F30F0000000000000000000000000000 | 1 0 0 3 B 0 0 0 0 0 0 0 0 0 00000000 00000000 2 00003000
0 0 0 1 1 00000000 00006000 00007000 C3000000000000000000000000000000 | 0 0 0 3 B 0 0 0 0 0 0 0 0 0 00000000 00000000 1 00005000
1 0 0 0 0 00000000 00000000 00000000 90000000000000000000000000000000 | 0 0 0 3 6 0 0 0 0 0 0 0 0 0 00000000 00000000 1 00006000
1 1 0 0 0 00000000 00000000 00000000 90000000000000000000000000000000 | 0 0 0 3 6 0 0 0 0 0 0 0 0 0 00000000 00000000 1 00006001
0 0 0 0 0 00000000 00000000 00000000 90000000000000000000000000000000 | 0 0 0 3 6 0 0 0 0 0 0 0 0 0 00000000 00000000 1 00006001
